//--- source/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN       32
`define RV_REG_BITS   5
`define RV_IMEM_WORDS 256 // power of two so addresses wrap
`define RV_DMEM_WORDS 256

// major opcodes, inst[6:0]
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011

`define RV_F3_ADD  3'b000 // also SUB
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SRL  3'b101 // also SRA
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

`define RV_F3_WORD 3'b010 // LW / SW only
`define RV_F3_JALR 3'b000

`define RV_F7_BASE 7'b0000000
`define RV_F7_ALT  7'b0100000 // SUB, SRA, SRAI

`endif

//--- source/rvPkg.sv
`include "rv_consts.svh"

package rvPkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_REG_BITS-1:0] regIdx_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_PASS_B, // LUI
        ALU_ADD_PC  // AUIPC
    } aluOp_t;

    typedef enum logic [2:0] {
        CLS_ALU_REG, CLS_ALU_IMM, CLS_UPPER, CLS_JAL,
        CLS_JALR, CLS_BRANCH, CLS_LOAD, CLS_STORE
    } instClass_t;

    typedef enum logic [1:0] {
        RUN_IDLE, RUN_ACTIVE, RUN_HALTED
    } runState_t;

    typedef struct packed {
        instClass_t iClass;
        aluOp_t     aluOp;
        logic [2:0] funct3;
        regIdx_t    rs1;
        regIdx_t    rs2;
        regIdx_t    rd;
        word_t      imm;     // already picked for the class
        logic       illegal;
    } decoded_t;

    typedef struct packed {
        logic  valid;
        word_t addr; // word index into imem
        word_t inst;
    } progWrite_t;

    typedef struct packed {
        logic    valid;
        word_t   pc;
        logic    rdWrite; // never set for x0
        regIdx_t rd;
        word_t   rdValue;
        logic    memWrite;
        word_t   memAddr;
        word_t   memData;
    } retire_t;

endpackage

//--- source/instDecode.sv
`include "rv_consts.svh"

module instDecode (
    input  rvPkg::word_t    inst,
    output rvPkg::decoded_t dec
);
    logic [6:0]   opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    rvPkg::word_t immI, immS, immB, immU, immJ;

    function automatic rvPkg::aluOp_t aluSel(input logic [2:0] f3, input logic alt);
        case (f3)
            `RV_F3_ADD:  aluSel = alt ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
            `RV_F3_SLL:  aluSel = rvPkg::ALU_SLL;
            `RV_F3_SLT:  aluSel = rvPkg::ALU_SLT;
            `RV_F3_SLTU: aluSel = rvPkg::ALU_SLTU;
            `RV_F3_XOR:  aluSel = rvPkg::ALU_XOR;
            `RV_F3_SRL:  aluSel = alt ? rvPkg::ALU_SRA : rvPkg::ALU_SRL;
            `RV_F3_OR:   aluSel = rvPkg::ALU_OR;
            `RV_F3_AND:  aluSel = rvPkg::ALU_AND;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25]; // doubles as immI[11:5] for shifts

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'b0};
    assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec.iClass  = rvPkg::CLS_ALU_REG;
        dec.aluOp   = rvPkg::ALU_ADD; // loads, stores, jumps use ADD
        dec.funct3  = funct3;
        dec.rs1     = inst[19:15];
        dec.rs2     = inst[24:20];
        dec.rd      = inst[11:7];
        dec.imm     = immI;
        dec.illegal = 1'b0;
        case (opcode)
            `RV_OP_REG: begin
                dec.aluOp = aluSel(funct3, funct7[5]);
                if (funct3 == `RV_F3_ADD || funct3 == `RV_F3_SRL)
                    dec.illegal = funct7 != `RV_F7_BASE && funct7 != `RV_F7_ALT;
                else
                    dec.illegal = funct7 != `RV_F7_BASE;
            end
            `RV_OP_IMM: begin
                dec.iClass = rvPkg::CLS_ALU_IMM;
                dec.aluOp  = aluSel(funct3, funct3 == `RV_F3_SRL && funct7[5]); // no SUBI
                if (funct3 == `RV_F3_SLL)
                    dec.illegal = funct7 != `RV_F7_BASE;
                else if (funct3 == `RV_F3_SRL)
                    dec.illegal = funct7 != `RV_F7_BASE && funct7 != `RV_F7_ALT;
            end
            `RV_OP_LUI: begin
                dec.iClass = rvPkg::CLS_UPPER;
                dec.aluOp  = rvPkg::ALU_PASS_B;
                dec.imm    = immU;
            end
            `RV_OP_AUIPC: begin
                dec.iClass = rvPkg::CLS_UPPER;
                dec.aluOp  = rvPkg::ALU_ADD_PC;
                dec.imm    = immU;
            end
            `RV_OP_JAL: begin
                dec.iClass = rvPkg::CLS_JAL;
                dec.imm    = immJ;
            end
            `RV_OP_JALR: begin
                dec.iClass  = rvPkg::CLS_JALR;
                dec.illegal = funct3 != `RV_F3_JALR;
            end
            `RV_OP_BRANCH: begin
                dec.iClass  = rvPkg::CLS_BRANCH;
                dec.imm     = immB;
                dec.illegal = !(funct3 inside {`RV_F3_BEQ, `RV_F3_BNE, `RV_F3_BLT,
                                               `RV_F3_BGE, `RV_F3_BLTU, `RV_F3_BGEU});
            end
            `RV_OP_LOAD: begin
                dec.iClass  = rvPkg::CLS_LOAD;
                dec.illegal = funct3 != `RV_F3_WORD; // byte/half not supported
            end
            `RV_OP_STORE: begin
                dec.iClass  = rvPkg::CLS_STORE;
                dec.imm     = immS;
                dec.illegal = funct3 != `RV_F3_WORD;
            end
            default: dec.illegal = 1'b1; // unknown opcode
        endcase
    end

endmodule

//--- source/aluUnit.sv
`include "rv_consts.svh"

module aluUnit (
    input  rvPkg::decoded_t dec,
    input  rvPkg::word_t    pc,
    input  rvPkg::word_t    rs1Val,
    input  rvPkg::word_t    rs2Val,
    output rvPkg::word_t    result,
    output rvPkg::word_t    effAddr
);
    rvPkg::word_t opB;
    logic [4:0]   shamt;
    logic         signedLt;
    logic         unsignedLt;

    // register ops take rs2, everything else takes the immediate
    assign opB   = (dec.iClass == rvPkg::CLS_ALU_REG) ? rs2Val : dec.imm;
    assign shamt = opB[4:0];

    assign signedLt   = $signed(rs1Val) < $signed(opB);
    assign unsignedLt = rs1Val < opB;

    always_comb begin
        case (dec.aluOp)
            rvPkg::ALU_ADD:
                result = rs1Val + opB;
            rvPkg::ALU_SUB:
                result = rs1Val - opB;
            rvPkg::ALU_SLL:
                result = rs1Val << shamt;
            rvPkg::ALU_SLT:
                result = {{(`RV_XLEN-1){1'b0}}, signedLt};
            rvPkg::ALU_SLTU:
                result = {{(`RV_XLEN-1){1'b0}}, unsignedLt};
            rvPkg::ALU_XOR:
                result = rs1Val ^ opB;
            rvPkg::ALU_SRL:
                result = rs1Val >> shamt;
            rvPkg::ALU_SRA:
                result = rvPkg::word_t'($signed(rs1Val) >>> shamt); // sign fill
            rvPkg::ALU_OR:
                result = rs1Val | opB; // bitwise
            rvPkg::ALU_AND:
                result = rs1Val & opB;
            rvPkg::ALU_PASS_B:
                result = opB; // LUI
            rvPkg::ALU_ADD_PC:
                result = pc + opB; // AUIPC
            default:
                result = '0;
        endcase
    end

    // dec.imm is immI for loads and immS for stores
    assign effAddr = rs1Val + dec.imm;

endmodule

//--- source/pcSequencer.sv
`include "rv_consts.svh"

module pcSequencer (
    input  logic            clk,
    input  logic            rst,
    input  logic            advance,
    input  rvPkg::decoded_t dec,
    input  rvPkg::word_t    rs1Val,
    input  rvPkg::word_t    rs2Val,
    output rvPkg::word_t    pc,
    output rvPkg::word_t    linkValue,
    output logic            misaligned
);
    rvPkg::word_t seqPc, target, jalrSum, pcNext;
    logic         takeBranch;
    logic         redirect;

    assign seqPc     = pc + rvPkg::word_t'(4);
    assign linkValue = seqPc;
    assign jalrSum   = rs1Val + dec.imm;

    always_comb begin
        case (dec.funct3)
            `RV_F3_BEQ:  takeBranch = rs1Val == rs2Val;
            `RV_F3_BNE:  takeBranch = rs1Val != rs2Val;
            `RV_F3_BLT:  takeBranch = $signed(rs1Val) < $signed(rs2Val);
            `RV_F3_BGE:  takeBranch = $signed(rs1Val) >= $signed(rs2Val);
            `RV_F3_BLTU: takeBranch = rs1Val < rs2Val;
            `RV_F3_BGEU: takeBranch = rs1Val >= rs2Val;
            default:     takeBranch = 1'b0; // reserved, decode flags it
        endcase
    end

    always_comb begin
        target   = pc + dec.imm;
        redirect = 1'b0;
        case (dec.iClass)
            rvPkg::CLS_JAL:    redirect = 1'b1;
            rvPkg::CLS_JALR: begin
                target   = {jalrSum[`RV_XLEN-1:1], 1'b0}; // low bit dropped
                redirect = 1'b1;
            end
            rvPkg::CLS_BRANCH: redirect = takeBranch;
            default:           redirect = 1'b0;
        endcase
    end

    assign pcNext     = redirect ? target : seqPc;
    assign misaligned = redirect && (target[1:0] != 2'b00); // only taken targets fault

    always_ff @(posedge clk) begin
        if (!rst)
            pc <= '0;
        else if (advance)
            pc <= pcNext;
    end

    pcAligned: assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00);

endmodule

//--- source/runControl.sv
module runControl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic fault,
    output logic running,
    output logic halt
);
    rvPkg::runState_t state;
    rvPkg::runState_t stateNext;

    always_comb begin
        stateNext = state;
        case (state)
            rvPkg::RUN_IDLE: begin
                if (start)
                    stateNext = rvPkg::RUN_ACTIVE;
            end
            rvPkg::RUN_ACTIVE: begin
                if (fault)
                    stateNext = rvPkg::RUN_HALTED;
            end
            default: stateNext = rvPkg::RUN_HALTED; // sticky until reset
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst)
            state <= rvPkg::RUN_IDLE;
        else
            state <= stateNext;
    end

    // the single advance enable for pc, regs and dmem
    assign running = (state == rvPkg::RUN_ACTIVE) && !fault;
    assign halt    = state == rvPkg::RUN_HALTED;

    haltSticky: assert property (
        @(posedge clk) disable iff (!rst)
        state == rvPkg::RUN_HALTED |=> state == rvPkg::RUN_HALTED
    );

endmodule

//--- source/regFile.sv
`include "rv_consts.svh"

module regFile (
    input  logic           clk,
    input  logic           rst,
    input  rvPkg::regIdx_t rdAddrA,
    input  rvPkg::regIdx_t rdAddrB,
    output rvPkg::word_t   rdDataA,
    output rvPkg::word_t   rdDataB,
    input  logic           wrEn,
    input  rvPkg::regIdx_t wrAddr,
    input  rvPkg::word_t   wrData
);
    localparam int NumRegs = 1 << `RV_REG_BITS;

    rvPkg::word_t regs [0:NumRegs-1];

    // x0 is cleared by reset and never written
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NumRegs; i++)
                regs[i] <= '0;
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

//--- source/wordMem.sv
`include "rv_consts.svh"

module wordMem #(
    parameter int depth = `RV_DMEM_WORDS // power of two
) (
    input  logic         clk,
    input  rvPkg::word_t rdAddr,
    output rvPkg::word_t rdData,
    input  logic         wrEn,
    input  rvPkg::word_t wrAddr,
    input  rvPkg::word_t wrData
);
    localparam int IdxBits = $clog2(depth);

    rvPkg::word_t       mem [0:depth-1];
    logic [IdxBits-1:0] rdIdx;
    logic [IdxBits-1:0] wrIdx;

    // byte address in, bits above the upper index bit fall away
    assign rdIdx = rdAddr[IdxBits+1:2];
    assign wrIdx = wrAddr[IdxBits+1:2];

    assign rdData = mem[rdIdx]; // async read

    always_ff @(posedge clk) begin
        if (wrEn)
            mem[wrIdx] <= wrData;
    end

endmodule

//--- source/rvCore.sv
`include "rv_consts.svh"

module rvCore (
    input  logic              clk,
    input  logic              rst,
    input  rvPkg::progWrite_t progWrite,
    input  logic              start,
    output rvPkg::retire_t    retire,
    output logic              halt
);
    rvPkg::decoded_t dec;
    rvPkg::word_t    pc, inst, rs1Val, rs2Val, aluResult, effAddr;
    rvPkg::word_t    linkValue, loadData, rdValue, imemWrAddr;
    logic            running, fault, pcMisaligned, addrMisaligned;
    logic            writesRd, rfWrEn, dmemWrEn, imemWrEn;

    // program load only while idle
    assign imemWrEn   = progWrite.valid && !running && !halt;
    assign imemWrAddr = {progWrite.addr[`RV_XLEN-3:0], 2'b00};

    wordMem #(.depth(`RV_IMEM_WORDS)) imem (
        .clk(clk), .rdAddr(pc), .rdData(inst),
        .wrEn(imemWrEn), .wrAddr(imemWrAddr), .wrData(progWrite.inst)
    );

    instDecode decoder (.inst(inst), .dec(dec));

    regFile regs (
        .clk(clk), .rst(rst),
        .rdAddrA(dec.rs1), .rdAddrB(dec.rs2), .rdDataA(rs1Val), .rdDataB(rs2Val),
        .wrEn(rfWrEn), .wrAddr(dec.rd), .wrData(rdValue)
    );

    aluUnit alu (
        .dec(dec), .pc(pc), .rs1Val(rs1Val), .rs2Val(rs2Val),
        .result(aluResult), .effAddr(effAddr)
    );

    pcSequencer pcSeq (
        .clk(clk), .rst(rst), .advance(running), .dec(dec),
        .rs1Val(rs1Val), .rs2Val(rs2Val),
        .pc(pc), .linkValue(linkValue), .misaligned(pcMisaligned)
    );

    wordMem #(.depth(`RV_DMEM_WORDS)) dmem (
        .clk(clk), .rdAddr(effAddr), .rdData(loadData),
        .wrEn(dmemWrEn), .wrAddr(effAddr), .wrData(rs2Val)
    );

    runControl ctrl (
        .clk(clk), .rst(rst), .start(start), .fault(fault),
        .running(running), .halt(halt)
    );

    assign addrMisaligned = (dec.iClass inside {rvPkg::CLS_LOAD, rvPkg::CLS_STORE})
                            && (effAddr[1:0] != 2'b00);
    assign fault = dec.illegal || pcMisaligned || addrMisaligned;

    assign writesRd = !(dec.iClass inside {rvPkg::CLS_BRANCH, rvPkg::CLS_STORE})
                      && (dec.rd != '0);
    assign rfWrEn   = running && writesRd;
    assign dmemWrEn = running && (dec.iClass == rvPkg::CLS_STORE);

    always_comb begin
        case (dec.iClass)
            rvPkg::CLS_JAL, rvPkg::CLS_JALR: rdValue = linkValue; // pc + 4
            rvPkg::CLS_LOAD:                 rdValue = loadData;
            default:                         rdValue = aluResult;
        endcase
    end

    always_comb begin
        retire.valid    = running;
        retire.pc       = pc;
        retire.rdWrite  = rfWrEn;
        retire.rd       = dec.rd;
        retire.rdValue  = rdValue;
        retire.memWrite = dmemWrEn;
        retire.memAddr  = effAddr;
        retire.memData  = rs2Val;
    end

    // halt state in runControl must block every write path here
    noWriteHalted: assert property (
        @(posedge clk) disable iff (!rst)
        halt |-> !(rfWrEn || dmemWrEn || retire.valid)
    );

endmodule

//--- dv/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

rvPkg::word_t refRegs [0:31];
rvPkg::word_t refImem [0:`RV_IMEM_WORDS-1]; // mirror of every progWrite
rvPkg::word_t refDmem [0:`RV_DMEM_WORDS-1]; // kept across resets like dmem
rvPkg::word_t refPc;
logic         refFault;

// predicts the retire record at refPc and commits it unless it faults
function automatic rvPkg::retire_t predictRetire();
    rvPkg::retire_t r;
    rvPkg::word_t   inst, a, b, b2, immI, immS, immB, immJ, res, nextPc, addr;
    logic [6:0]     op, f7;
    logic [2:0]     f3;
    logic           bad, take, wr, alt, isReg;
    inst   = refImem[(refPc >> 2) % `RV_IMEM_WORDS];
    op     = inst[6:0];
    f3     = inst[14:12];
    f7     = inst[31:25];
    a      = refRegs[inst[19:15]];
    b      = refRegs[inst[24:20]];
    immI   = {{20{inst[31]}}, inst[31:20]};
    immS   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    immB   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    immJ   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    r      = '0;
    r.pc   = refPc;
    r.rd   = inst[11:7];
    nextPc = refPc + 32'd4;
    res    = '0;
    bad    = 1'b0;
    wr     = 1'b1;
    case (op)
        `RV_OP_REG, `RV_OP_IMM: begin
            isReg = op == `RV_OP_REG;
            b2    = isReg ? b : immI;
            alt   = f7 == `RV_F7_ALT && (isReg || f3 == `RV_F3_SRL); // no SUBI
            if (isReg)
                bad = f7 != `RV_F7_BASE
                      && !(f7 == `RV_F7_ALT && (f3 == `RV_F3_ADD || f3 == `RV_F3_SRL));
            else
                bad = (f3 == `RV_F3_SLL && f7 != `RV_F7_BASE)
                      || (f3 == `RV_F3_SRL && f7 != `RV_F7_BASE && f7 != `RV_F7_ALT);
            case (f3)
                `RV_F3_ADD:  res = alt ? a - b2 : a + b2;
                `RV_F3_SLL:  res = a << b2[4:0];
                `RV_F3_SLT:  res = {31'b0, $signed(a) < $signed(b2)};
                `RV_F3_SLTU: res = {31'b0, a < b2};
                `RV_F3_XOR:  res = a ^ b2;
                `RV_F3_SRL: begin
                    if (alt)
                        res = $signed(a) >>> b2[4:0]; // sign fill
                    else
                        res = a >> b2[4:0];
                end
                `RV_F3_OR:   res = a | b2;
                default:     res = a & b2;
            endcase
        end
        `RV_OP_LUI:   res = {inst[31:12], 12'b0};
        `RV_OP_AUIPC: res = refPc + {inst[31:12], 12'b0};
        `RV_OP_JAL: begin
            res    = refPc + 32'd4;
            nextPc = refPc + immJ;
        end
        `RV_OP_JALR: begin
            res    = refPc + 32'd4;
            nextPc = (a + immI) & ~32'd1;
            bad    = f3 != 3'b000;
        end
        `RV_OP_BRANCH: begin
            wr = 1'b0;
            case (f3)
                `RV_F3_BEQ:  take = a == b;
                `RV_F3_BNE:  take = a != b;
                `RV_F3_BLT:  take = $signed(a) < $signed(b);
                `RV_F3_BGE:  take = $signed(a) >= $signed(b);
                `RV_F3_BLTU: take = a < b;
                `RV_F3_BGEU: take = a >= b;
                default: begin
                    take = 1'b0;
                    bad  = 1'b1;
                end
            endcase
            if (take)
                nextPc = refPc + immB;
        end
        `RV_OP_LOAD: begin
            addr = a + immI;
            bad  = f3 != `RV_F3_WORD || addr[1:0] != 2'b00;
            if (!bad)
                res = refDmem[(addr >> 2) % `RV_DMEM_WORDS];
        end
        `RV_OP_STORE: begin
            wr         = 1'b0;
            addr       = a + immS;
            bad        = f3 != `RV_F3_WORD || addr[1:0] != 2'b00;
            r.memWrite = 1'b1;
            r.memAddr  = addr;
            r.memData  = b;
        end
        default: bad = 1'b1;
    endcase
    bad      = bad || nextPc[1:0] != 2'b00;
    refFault = bad;
    if (bad)
        return '0; // faulting instruction retires nothing
    r.valid   = 1'b1;
    r.rdWrite = wr && r.rd != 5'd0;
    r.rdValue = res;
    if (r.rdWrite)
        refRegs[r.rd] = res;
    if (r.memWrite)
        refDmem[(r.memAddr >> 2) % `RV_DMEM_WORDS] = r.memData;
    refPc = nextPc;
    return r;
endfunction

`endif

//--- dv/rvCoreTb.sv
`include "rv_consts.svh"

module rvCoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ResetCycles = 16;
    localparam int NumTests    = 3;
    localparam int MaxProgLen  = 64;
    localparam int TailCycles  = 4;
    // reset, load, run and tail of the longest program
    localparam int CyclesPerTest = ResetCycles + 2 * MaxProgLen + TailCycles + 8;

    logic              clk;
    logic              rst;
    rvPkg::progWrite_t progWrite;
    logic              start;
    rvPkg::retire_t    retire;
    logic              halt;

    integer       seed;
    int           errCount;
    int           checkCount;
    logic         checking;
    logic         refHalted;
    rvPkg::word_t prog [$];

    `include "refModel.svh"

    rvCore DUT (
        .clk(clk), .rst(rst), .progWrite(progWrite), .start(start),
        .retire(retire), .halt(halt)
    );

    always #50 clk = ~clk;

    function automatic rvPkg::word_t encR(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic rvPkg::word_t encI(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rvPkg::word_t encS(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, `RV_F3_WORD, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic rvPkg::word_t encB(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic rvPkg::word_t encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    task automatic compareField(input string name, input rvPkg::word_t exp,
            input rvPkg::word_t act);
        if (act !== exp) begin
            errCount++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkRetire(input rvPkg::retire_t exp, input rvPkg::retire_t act);
        checkCount++;
        compareField("retire.valid", 32'(exp.valid), 32'(act.valid));
        compareField("retire.rdWrite", 32'(exp.rdWrite), 32'(act.rdWrite));
        compareField("retire.memWrite", 32'(exp.memWrite), 32'(act.memWrite));
        if (exp.valid)
            compareField("retire.pc", exp.pc, act.pc);
        if (exp.valid && exp.rdWrite) begin
            compareField("retire.rd", 32'(exp.rd), 32'(act.rd));
            compareField("retire.rdValue", exp.rdValue, act.rdValue);
        end
        if (exp.valid && exp.memWrite) begin
            compareField("retire.memAddr", exp.memAddr, act.memAddr);
            compareField("retire.memData", exp.memData, act.memData);
        end
    endtask

    task automatic checkHalt(input logic exp, input logic act);
        checkCount++;
        if (act !== exp) begin
            errCount++;
            $display("mismatch at %0t: halt expected %b got %b", $time, exp, act);
        end
    endtask

    // random ALU, LUI and AUIPC mix over x0..x7
    task automatic buildAluProgram();
        logic [31:0] rnd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        prog.delete();
        for (int r = 1; r < 8; r++) begin
            rnd = $random(seed);
            prog.push_back({rnd[31:12], 5'(r), `RV_OP_LUI});
            prog.push_back(encI(rnd[11:0], 5'(r), `RV_F3_ADD, 5'(r), `RV_OP_IMM));
        end
        for (int n = 0; n < 40; n++) begin
            rnd = $random(seed);
            f3  = rnd[2:0];
            f7  = (rnd[15] && (f3 == `RV_F3_ADD || f3 == `RV_F3_SRL)) ? `RV_F7_ALT : `RV_F7_BASE;
            imm = rnd[31:20];
            case (rnd[14:12])
                3'd0, 3'd1, 3'd2:
                    prog.push_back(encR(f7, {2'b0, rnd[11:9]}, {2'b0, rnd[8:6]}, f3,
                                        {2'b0, rnd[5:3]}));
                3'd3, 3'd4, 3'd5: begin
                    if (f3 == `RV_F3_SLL || f3 == `RV_F3_SRL)
                        imm[11:5] = (f3 == `RV_F3_SRL) ? f7 : `RV_F7_BASE; // legal shamt form
                    prog.push_back(encI(imm, {2'b0, rnd[8:6]}, f3, {2'b0, rnd[5:3]}, `RV_OP_IMM));
                end
                3'd6:    prog.push_back({rnd[31:12], 2'b0, rnd[5:3], `RV_OP_LUI});
                default: prog.push_back({rnd[31:12], 2'b0, rnd[5:3], `RV_OP_AUIPC});
            endcase
        end
        prog.push_back(32'h0); // unknown opcode
    endtask

    task automatic buildBranchProgram();
        prog.delete();
        prog.push_back(encI(12'd5, 0, `RV_F3_ADD, 1, `RV_OP_IMM));   // 0
        prog.push_back(encI(12'd5, 0, `RV_F3_ADD, 2, `RV_OP_IMM));   // 4
        prog.push_back(encB(13'd8, 2, 1, `RV_F3_BEQ));               // 8 taken
        prog.push_back(32'h0);
        prog.push_back(encB(13'd8, 2, 1, `RV_F3_BNE));               // 16 falls through
        prog.push_back(encB(13'd8, 2, 1, `RV_F3_BGE));               // 20 taken
        prog.push_back(32'h0);
        prog.push_back(encJ(21'd8, 3));                              // 28
        prog.push_back(32'h0);
        prog.push_back(encI(12'd49, 0, `RV_F3_ADD, 4, `RV_OP_IMM));  // 36
        prog.push_back(encI(12'd0, 4, `RV_F3_JALR, 5, `RV_OP_JALR)); // 40 lands on 48
        prog.push_back(32'h0);
        prog.push_back(encB(13'd8, 1, 0, `RV_F3_BLTU));              // 48 taken
        prog.push_back(32'h0);
        prog.push_back(encB(13'd8, 1, 0, `RV_F3_BGEU));              // 56 falls through
        prog.push_back(encI(12'hfff, 0, `RV_F3_ADD, 6, `RV_OP_IMM)); // 60 x6 = -1
        prog.push_back(encB(13'd8, 1, 6, `RV_F3_BLT));               // 64 signed, taken
        prog.push_back(32'h0);
        prog.push_back(encB(13'h1fb8, 6, 1, `RV_F3_BLT));            // 72 not taken
        prog.push_back(encJ(21'd8, 0));                              // 76 link dropped
        prog.push_back(32'h0);
        prog.push_back(encR(7'h01, 2, 1, `RV_F3_ADD, 7));            // 84 bad funct7
    endtask

    task automatic buildMemProgram();
        logic [31:0] rnd;
        logic [31:0] val;
        rnd = $random(seed);
        val = $random(seed);
        prog.delete();
        prog.push_back(encI({4'b0, rnd[7:2], 2'b00}, 0, `RV_F3_ADD, 1, `RV_OP_IMM));
        prog.push_back({val[31:12], 5'd2, `RV_OP_LUI});
        prog.push_back(encI(val[11:0], 2, `RV_F3_ADD, 2, `RV_OP_IMM));
        prog.push_back(encS(12'd8, 2, 1));
        prog.push_back(encI(12'd8, 1, `RV_F3_WORD, 3, `RV_OP_LOAD));
        prog.push_back(encS(12'hffc, 3, 1));                         // offset -4
        prog.push_back(encI(12'hffc, 1, `RV_F3_WORD, 4, `RV_OP_LOAD));
        prog.push_back(encR(`RV_F7_BASE, 4, 3, `RV_F3_XOR, 5));
        prog.push_back(encI(12'd6, 1, `RV_F3_WORD, 6, `RV_OP_LOAD));  // misaligned
    endtask

    // reset, load, start, then let the checker follow the run until halt
    task automatic runProgram();
        rst <= 1'b0;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < 32; i++)
            refRegs[i] = '0;
        refPc     = '0;
        refHalted = 1'b0;
        foreach (prog[i]) begin
            @(posedge clk);
            progWrite.valid <= 1'b1;
            progWrite.addr  <= i;
            progWrite.inst  <= prog[i];
            refImem[i] = prog[i];
        end
        @(posedge clk);
        progWrite.valid <= 1'b0;
        @(negedge clk);
        checkRetire('0, retire); // idle, nothing retires
        checkHalt(1'b0, halt);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        checking = 1'b1;
        wait (refHalted);
        repeat (TailCycles) @(posedge clk); // halt must hold with no retire
        checking = 1'b0;
    endtask

    always @(negedge clk) begin
        if (checking) begin
            if (refHalted) begin
                checkRetire('0, retire);
                checkHalt(1'b1, halt);
            end else begin
                checkRetire(predictRetire(), retire);
                checkHalt(1'b0, halt);
                refHalted = refFault;
            end
        end
    end

    initial begin
        seed       = 32590;
        clk        = 1'b0;
        rst        = 1'b0;
        start      = 1'b0;
        progWrite  = '0;
        checking   = 1'b0;
        refHalted  = 1'b0;
        errCount   = 0;
        checkCount = 0;
        buildAluProgram();
        runProgram();
        buildBranchProgram();
        runProgram();
        buildMemProgram();
        runProgram();
        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        #(NumTests * CyclesPerTest * 100);
        $display("run timed out after %0d cycles without finishing", NumTests * CyclesPerTest);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+source
+incdir+dv
source/rvPkg.sv
source/instDecode.sv
source/aluUnit.sv
source/pcSequencer.sv
source/runControl.sv
source/regFile.sv
source/wordMem.sv
source/rvCore.sv
dv/rvCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module rvCoreTb -o rvCoreSim

simOut=$(./obj_dir/rvCoreSim)
echo "$simOut"

if grep -q "Result: PASSED" <<< "$simOut"; then
    exit 0
else
    exit 1
fi
